/* flist.f */
+incdir+include
verilog/conv_data_pkg.sv
verilog/conv_ctrl_pkg.sv
verilog/coef_loader.sv
verilog/window_buffer.sv
verilog/channel_mac.sv
verilog/scan_ctrl.sv
verilog/conv_layer.sv
verification/conv_checker.sv
verification/conv_layer_tb.sv

/* Bender.yml */
package:
  name: conv_layer

export_include_dirs:
  - include

sources:
  - verilog/conv_data_pkg.sv
  - verilog/conv_ctrl_pkg.sv
  - verilog/coef_loader.sv
  - verilog/window_buffer.sv
  - verilog/channel_mac.sv
  - verilog/scan_ctrl.sv
  - verilog/conv_layer.sv
  - target: simulation
    files:
      - verification/conv_checker.sv
      - verification/conv_layer_tb.sv

/* verification/conv_layer_tb.sv */
`default_nettype none

`include "conv_macros.svh"

module conv_layer_tb;

	localparam int N_PIX     = `CONV_IMG_WIDTH * `CONV_IMG_WIDTH;
	localparam int N_W       = `CONV_TAPS * `CONV_OUT_CH;
	localparam int N_ENTRIES = 4;
	localparam int LIMIT     = N_ENTRIES * 160 + 100;

	localparam logic [1:0] IMG_RAMP    = 2'd0;
	localparam logic [1:0] IMG_FULL    = 2'd1;
	localparam logic [1:0] IMG_RANDOM  = 2'd2;
	localparam logic [1:0] WGT_RANDOM  = 2'd0;
	localparam logic [1:0] WGT_MIN     = 2'd1;
	localparam logic [1:0] WGT_CENTRE  = 2'd2;
	localparam logic [1:0] BIAS_ZERO   = 2'd0;
	localparam logic [1:0] BIAS_RANDOM = 2'd1;
	localparam logic [1:0] BIAS_MIN    = 2'd2;

	typedef struct packed {
		logic [1:0] img;
		logic [1:0] wgt;
		logic [1:0] bias;
		logic [7:0] exp_saves;
		logic [7:0] exp_w_reads;
		logic [7:0] exp_b_reads;
	} entry_t;

	logic                   clk = 1'b0;
	logic                   rst;
	logic                   weight_store_done;
	logic                   bias_store_done;
	logic                   pixel_store_done;
	conv_data_pkg::pixel_t  pixel_data;
	conv_data_pkg::weight_t weight_data;
	conv_data_pkg::bias_t   bias_data;
	conv_ctrl_pkg::addr_t   read_weight_addr;
	logic                   read_weight_signal;
	conv_ctrl_pkg::addr_t   read_bias_addr;
	logic                   read_bias_signal;
	logic                   read_pixel_signal;
	conv_ctrl_pkg::coord_t  read_row_addr;
	conv_ctrl_pkg::coord_t  read_col_addr;
	logic                   save_enable;
	conv_ctrl_pkg::coord_t  output_row;
	conv_ctrl_pkg::coord_t  output_col;
	conv_data_pkg::result_t output_data;
	logic                   layer2_calculation_done;

	conv_data_pkg::pixel_t  pix_mem [N_PIX];
	conv_data_pkg::weight_t weight_mem [N_W];
	conv_data_pkg::bias_t   bias_mem [`CONV_OUT_CH];
	entry_t                 stim_table [N_ENTRIES];
	logic [31:0]            lfsr;
	int                     count_errs;
	int                     mismatches;
	int                     cycles;

	conv_layer conv_layer_i (.*);

	conv_checker conv_checker_i (.*);

	initial
		forever #2 clk = ~clk;

	// external memories with one cycle read latency
	always @(posedge clk)
	begin
		if (read_pixel_signal)
			pixel_data <= pix_mem[read_row_addr * `CONV_IMG_WIDTH + read_col_addr];
		if (read_weight_signal)
			weight_data <= weight_mem[read_weight_addr];
		if (read_bias_signal)
			bias_data <= bias_mem[read_bias_addr];
	end

	function automatic logic [31:0] next_lfsr(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		else
			return s >> 1;
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = next_lfsr(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic fill_memories(input entry_t e);
		for (int i = 0; i < N_PIX; i++)
			case (e.img)
				IMG_RAMP: pix_mem[i] = conv_data_pkg::pixel_t'(i * 4);
				IMG_FULL: pix_mem[i] = 8'hff;
				default: pix_mem[i] = conv_data_pkg::pixel_t'(random_bits(8));
			endcase
		// centre pattern puts channel+1 on tap 4 only
		for (int i = 0; i < N_W; i++)
			case (e.wgt)
				WGT_MIN: weight_mem[i] = 8'h80;
				WGT_CENTRE: weight_mem[i] = (i / `CONV_OUT_CH == `CONV_TAPS / 2) ?
					conv_data_pkg::weight_t'(i % `CONV_OUT_CH + 1) : '0;
				default: weight_mem[i] = conv_data_pkg::weight_t'(random_bits(8));
			endcase
		for (int c = 0; c < `CONV_OUT_CH; c++)
			case (e.bias)
				BIAS_ZERO: bias_mem[c] = '0;
				BIAS_MIN: bias_mem[c] = 16'h8000;
				default: bias_mem[c] = conv_data_pkg::bias_t'(random_bits(16));
			endcase
	endtask

	task automatic load_coefficients(input entry_t e);
		int w_reads;
		int b_reads;
		w_reads = 0;
		b_reads = 0;
		@(posedge clk);
		weight_store_done <= 1'b1;
		bias_store_done <= 1'b1;
		@(posedge clk);
		weight_store_done <= 1'b0;
		bias_store_done <= 1'b0;
		do
		begin
			@(negedge clk);
			w_reads += read_weight_signal;
			b_reads += read_bias_signal;
		end
		while (read_weight_signal || read_bias_signal);
		if (w_reads != e.exp_w_reads || b_reads != e.exp_b_reads)
		begin
			$display("%0d weight and %0d bias reads after the load, expected %0d and %0d",
				w_reads, b_reads, e.exp_w_reads, e.exp_b_reads);
			count_errs++;
		end
	endtask

	task automatic run_image(input entry_t e);
		int saves;
		saves = 0;
		@(posedge clk);
		pixel_store_done <= 1'b1;
		@(posedge clk);
		pixel_store_done <= 1'b0;
		do
		begin
			@(negedge clk);
			saves += save_enable;
		end
		while (!layer2_calculation_done);
		if (saves != e.exp_saves)
		begin
			$display("image gave %0d saves instead of %0d", saves, e.exp_saves);
			count_errs++;
		end
		@(negedge clk);
		if (save_enable || layer2_calculation_done || read_pixel_signal)
		begin
			$display("scan outputs still active in the cycle after the done pulse");
			count_errs++;
		end
	endtask

	initial
	begin
		cycles = 0;
		forever
		begin
			@(posedge clk);
			cycles++;
			if (cycles >= LIMIT)
			begin
				$display("run did not finish within %0d cycles", LIMIT);
				$display("Simulation failed");
				$finish;
			end
		end
	end

	initial
	begin
		rst = 1'b1;
		weight_store_done = 1'b0;
		bias_store_done = 1'b0;
		pixel_store_done = 1'b0;
		pixel_data = '0;
		weight_data = '0;
		bias_data = '0;
		lfsr = 32'h3808_dab4;
		count_errs = 0;
		// image, weights, bias, expected saves, weight reads, bias reads
		stim_table[0] = '{IMG_RAMP, WGT_CENTRE, BIAS_ZERO, 8'd36, 8'd36, 8'd4};
		stim_table[1] = '{IMG_RANDOM, WGT_RANDOM, BIAS_RANDOM, 8'd36, 8'd36, 8'd4};
		stim_table[2] = '{IMG_FULL, WGT_MIN, BIAS_MIN, 8'd36, 8'd36, 8'd4};
		stim_table[3] = '{IMG_RANDOM, WGT_RANDOM, BIAS_RANDOM, 8'd36, 8'd36, 8'd4};
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		for (int e = 0; e < N_ENTRIES; e++)
		begin
			fill_memories(stim_table[e]);
			load_coefficients(stim_table[e]);
			run_image(stim_table[e]);
		end
		repeat (4) @(posedge clk);
		$display("%0d value mismatches, %0d count errors", mismatches, count_errs);
		if (mismatches == 0 && count_errs == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/conv_checker.sv */
`default_nettype none

`include "conv_macros.svh"

module conv_checker (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   read_weight_signal,
	input  conv_ctrl_pkg::addr_t   read_weight_addr,
	input  logic                   read_bias_signal,
	input  conv_ctrl_pkg::addr_t   read_bias_addr,
	input  logic                   read_pixel_signal,
	input  conv_ctrl_pkg::coord_t  read_row_addr,
	input  conv_ctrl_pkg::coord_t  read_col_addr,
	input  logic                   save_enable,
	input  conv_ctrl_pkg::coord_t  output_row,
	input  conv_ctrl_pkg::coord_t  output_col,
	input  conv_data_pkg::result_t output_data,
	input  logic                   layer2_calculation_done,
	input  conv_data_pkg::pixel_t  pix_mem [`CONV_IMG_WIDTH*`CONV_IMG_WIDTH],
	input  conv_data_pkg::weight_t weight_mem [`CONV_TAPS*`CONV_OUT_CH],
	input  conv_data_pkg::bias_t   bias_mem [`CONV_OUT_CH],
	output int                     mismatches
);

	localparam int W    = `CONV_IMG_WIDTH;
	localparam int SIDE = `CONV_OUT_SIDE;

	int errs = 0;
	int w_next = 0;
	int b_next = 0;
	int pix_next = 0;
	int save_next = 0;

	assign mismatches = errs;

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
			errs++;
		end
	endtask

	// bias plus the products over the window whose top-left pixel is (r, c)
	function automatic int conv_reference(input int r, input int c, input int ch);
		int sum;
		int tap;
		sum = int'(bias_mem[ch]);
		for (int kr = 0; kr < `CONV_KERNEL; kr++)
			for (int kc = 0; kc < `CONV_KERNEL; kc++)
			begin
				tap = kr * `CONV_KERNEL + kc;
				sum += int'(pix_mem[(r + kr) * W + c + kc]) *
					int'(weight_mem[tap * `CONV_OUT_CH + ch]);
			end
		return sum;
	endfunction

	always @(negedge clk)
	begin
		if (rst)
		begin
			compare("read_weight_signal", read_weight_signal, 0);
			compare("read_bias_signal", read_bias_signal, 0);
			compare("read_pixel_signal", read_pixel_signal, 0);
			compare("save_enable", save_enable, 0);
			compare("layer2_calculation_done", layer2_calculation_done, 0);
			w_next = 0;
			b_next = 0;
			pix_next = 0;
			save_next = 0;
		end
		else
		begin
			// read bursts are contiguous, so a low read signal restarts the count
			if (read_weight_signal)
			begin
				compare("read_weight_addr", read_weight_addr, w_next);
				w_next++;
			end
			else
				w_next = 0;
			if (read_bias_signal)
			begin
				compare("read_bias_addr", read_bias_addr, b_next);
				b_next++;
			end
			else
				b_next = 0;
			if (read_pixel_signal)
			begin
				compare("read_row_addr", read_row_addr, pix_next / W);
				compare("read_col_addr", read_col_addr, pix_next % W);
				pix_next++;
			end
			else
				pix_next = 0;
			if (save_enable && save_next >= SIDE * SIDE)
			begin
				$display("save_enable high more than %0d times in one image at %0t",
					SIDE * SIDE, $time);
				errs++;
			end
			else if (save_enable)
			begin
				compare("output_row", output_row, save_next / SIDE);
				compare("output_col", output_col, save_next % SIDE);
				for (int ch = 0; ch < `CONV_OUT_CH; ch++)
					compare($sformatf("output_data[%0d]", ch), output_data[ch],
						conv_data_pkg::acc_t'(conv_reference(save_next / SIDE,
							save_next % SIDE, ch)));
				save_next++;
			end
			if (layer2_calculation_done)
			begin
				compare("save_enable", save_enable, 1);
				compare("save count at done", save_next, SIDE * SIDE);
				save_next = 0;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/conv_layer.sv */
`default_nettype none

`include "conv_macros.svh"

module conv_layer (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   weight_store_done,
	input  logic                   bias_store_done,
	input  logic                   pixel_store_done,
	input  conv_data_pkg::pixel_t  pixel_data,
	input  conv_data_pkg::weight_t weight_data,
	input  conv_data_pkg::bias_t   bias_data,
	output conv_ctrl_pkg::addr_t   read_weight_addr,
	output logic                   read_weight_signal,
	output conv_ctrl_pkg::addr_t   read_bias_addr,
	output logic                   read_bias_signal,
	output logic                   read_pixel_signal,
	output conv_ctrl_pkg::coord_t  read_row_addr,
	output conv_ctrl_pkg::coord_t  read_col_addr,
	output logic                   save_enable,
	output conv_ctrl_pkg::coord_t  output_row,
	output conv_ctrl_pkg::coord_t  output_col,
	output conv_data_pkg::result_t output_data,
	output logic                   layer2_calculation_done
);

	conv_data_pkg::weight_t weights [`CONV_TAPS][`CONV_OUT_CH];
	conv_data_pkg::bias_t   biases [`CONV_OUT_CH];
	conv_data_pkg::pixel_t  window [`CONV_TAPS];
	conv_data_pkg::acc_t    ch_result [`CONV_OUT_CH];

	coef_loader coef_loader_i (
		.clk                (clk),
		.rst                (rst),
		.weight_store_done  (weight_store_done),
		.bias_store_done    (bias_store_done),
		.weight_data        (weight_data),
		.bias_data          (bias_data),
		.read_weight_addr   (read_weight_addr),
		.read_bias_addr     (read_bias_addr),
		.read_weight_signal (read_weight_signal),
		.read_bias_signal   (read_bias_signal),
		.weights            (weights),
		.biases             (biases)
	);

	window_buffer window_buffer_i (
		.clk        (clk),
		.rst        (rst),
		.pixel_data (pixel_data),
		.window     (window)
	);

	scan_ctrl scan_ctrl_i (
		.clk                     (clk),
		.rst                     (rst),
		.pixel_store_done        (pixel_store_done),
		.read_pixel_signal       (read_pixel_signal),
		.read_row_addr           (read_row_addr),
		.read_col_addr           (read_col_addr),
		.save_enable             (save_enable),
		.output_row              (output_row),
		.output_col              (output_col),
		.layer2_calculation_done (layer2_calculation_done)
	);

	for (genvar c = 0; c < `CONV_OUT_CH; c++)
	begin : g_ch
		// per-channel column of the coefficient array
		conv_data_pkg::weight_t ch_weights [`CONV_TAPS];

		always_comb
		begin
			for (int t = 0; t < `CONV_TAPS; t++)
				ch_weights[t] = weights[t][c];
		end

		channel_mac channel_mac_i (
			.window  (window),
			.weights (ch_weights),
			.bias    (biases[c]),
			.result  (ch_result[c])
		);
	end

	always_comb
	begin
		for (int c = 0; c < `CONV_OUT_CH; c++)
			output_data[c] = ch_result[c];
	end

endmodule

`default_nettype wire

/* verilog/scan_ctrl.sv */
`default_nettype none

`include "conv_macros.svh"

module scan_ctrl (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  pixel_store_done,
	output logic                  read_pixel_signal,
	output conv_ctrl_pkg::coord_t read_row_addr,
	output conv_ctrl_pkg::coord_t read_col_addr,
	output logic                  save_enable,
	output conv_ctrl_pkg::coord_t output_row,
	output conv_ctrl_pkg::coord_t output_col,
	output logic                  layer2_calculation_done
);

	localparam conv_ctrl_pkg::coord_t LAST = conv_ctrl_pkg::coord_t'(`CONV_IMG_WIDTH - 1);
	localparam conv_ctrl_pkg::coord_t EDGE = conv_ctrl_pkg::coord_t'(`CONV_KERNEL - 1);

	conv_ctrl_pkg::scan_state_t state;
	conv_ctrl_pkg::coord_t      rd_row;
	conv_ctrl_pkg::coord_t      rd_col;
	conv_ctrl_pkg::coord_t      new_row;
	conv_ctrl_pkg::coord_t      new_col;
	logic [1:0]                 pix_dly;
	logic                       pix_valid;
	logic                       rd_last;

	function automatic conv_ctrl_pkg::coord_t wrap_inc(input conv_ctrl_pkg::coord_t v);
		return (v == LAST) ? '0 : v + 1'b1;
	endfunction

	assign read_pixel_signal = (state == conv_ctrl_pkg::sc_fill);
	assign read_row_addr     = rd_row;
	assign read_col_addr     = rd_col;
	assign rd_last           = (rd_row == LAST) && (rd_col == LAST);

	// new_row/new_col name the pixel in the newest window register
	assign pix_valid   = pix_dly[1];
	assign save_enable = pix_valid && (new_row >= EDGE) && (new_col >= EDGE);
	assign output_row  = new_row - EDGE;
	assign output_col  = new_col - EDGE;
	assign layer2_calculation_done = pix_valid && (new_row == LAST) && (new_col == LAST);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state   <= conv_ctrl_pkg::sc_idle;
			rd_row  <= '0;
			rd_col  <= '0;
			new_row <= '0;
			new_col <= '0;
			pix_dly <= '0;
		end
		else
		begin
			// read to window register takes two cycles
			pix_dly <= {pix_dly[0], read_pixel_signal};
			case (state)
				conv_ctrl_pkg::sc_idle:
					if (pixel_store_done)
						state <= conv_ctrl_pkg::sc_fill;
				conv_ctrl_pkg::sc_fill:
					if (rd_last)
						state <= conv_ctrl_pkg::sc_run;
				conv_ctrl_pkg::sc_run:
					if (layer2_calculation_done)
						state <= conv_ctrl_pkg::sc_idle;
				default: state <= conv_ctrl_pkg::sc_idle;
			endcase
			if (read_pixel_signal)
			begin
				rd_col <= wrap_inc(rd_col);
				if (rd_col == LAST)
					rd_row <= wrap_inc(rd_row);
			end
			// both counters wrap back to zero at the end of an image
			if (pix_valid)
			begin
				new_col <= wrap_inc(new_col);
				if (new_col == LAST)
					new_row <= wrap_inc(new_row);
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/channel_mac.sv */
`default_nettype none

`include "conv_macros.svh"

module channel_mac (
	input  conv_data_pkg::pixel_t  window [`CONV_TAPS],
	input  conv_data_pkg::weight_t weights [`CONV_TAPS],
	input  conv_data_pkg::bias_t   bias,
	output conv_data_pkg::acc_t    result
);

	conv_data_pkg::acc_t prod [`CONV_TAPS];
	conv_data_pkg::acc_t sum_l1 [4];
	conv_data_pkg::acc_t sum_l2 [2];
	conv_data_pkg::acc_t tail;

	always_comb
	begin
		// pixels are unsigned, so one zero bit before going signed
		for (int t = 0; t < `CONV_TAPS; t++)
			prod[t] = $signed({1'b0, window[t]}) * weights[t];
		for (int k = 0; k < 4; k++)
			sum_l1[k] = prod[2*k] + prod[2*k + 1];
		sum_l2[0] = sum_l1[0] + sum_l1[1];
		sum_l2[1] = sum_l1[2] + sum_l1[3];
		tail = prod[`CONV_TAPS-1] + conv_data_pkg::acc_t'(bias);
		result = (sum_l2[0] + sum_l2[1]) + tail;
	end

endmodule

`default_nettype wire

/* verilog/window_buffer.sv */
`default_nettype none

`include "conv_macros.svh"

module window_buffer (
	input  logic                  clk,
	input  logic                  rst,
	input  conv_data_pkg::pixel_t pixel_data,
	output conv_data_pkg::pixel_t window [`CONV_TAPS]
);

	localparam int K   = `CONV_KERNEL;
	localparam int DLY = `CONV_IMG_WIDTH - `CONV_KERNEL;

	// line[r] feeds window row r from the row below
	conv_data_pkg::pixel_t line [K-1][DLY];
	conv_data_pkg::pixel_t row_in [K];

	always_comb
	begin
		row_in[K-1] = pixel_data;
		for (int r = 0; r < K - 1; r++)
			row_in[r] = line[r][DLY-1];
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < `CONV_TAPS; i++)
				window[i] <= '0;
			for (int r = 0; r < K - 1; r++)
				for (int d = 0; d < DLY; d++)
					line[r][d] <= '0;
		end
		else
		begin
			// newest pixel of each row sits at the right
			for (int r = 0; r < K; r++)
			begin
				window[r*K + K - 1] <= row_in[r];
				for (int c = 0; c < K - 1; c++)
					window[r*K + c] <= window[r*K + c + 1];
			end
			for (int r = 0; r < K - 1; r++)
			begin
				line[r][0] <= window[(r + 1) * K];
				for (int d = 1; d < DLY; d++)
					line[r][d] <= line[r][d-1];
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/coef_loader.sv */
`default_nettype none

`include "conv_macros.svh"

module coef_loader (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   weight_store_done,
	input  logic                   bias_store_done,
	input  conv_data_pkg::weight_t weight_data,
	input  conv_data_pkg::bias_t   bias_data,
	output conv_ctrl_pkg::addr_t   read_weight_addr,
	output conv_ctrl_pkg::addr_t   read_bias_addr,
	output logic                   read_weight_signal,
	output logic                   read_bias_signal,
	output conv_data_pkg::weight_t weights [`CONV_TAPS][`CONV_OUT_CH],
	output conv_data_pkg::bias_t   biases [`CONV_OUT_CH]
);

	localparam int N_W = `CONV_TAPS * `CONV_OUT_CH;
	localparam int N_B = `CONV_OUT_CH;

	// index 0 is the weight sequencer, index 1 the bias sequencer
	localparam conv_ctrl_pkg::addr_t LOAD_LEN [2] = '{
		conv_ctrl_pkg::addr_t'(N_W),
		conv_ctrl_pkg::addr_t'(N_B)
	};

	conv_ctrl_pkg::load_state_t state [2];
	conv_ctrl_pkg::addr_t       rd_cnt [2];
	logic                       start [2];
	logic                       rd_on [2];
	logic                       cap_en [2];

	always_comb
	begin
		start[0] = weight_store_done;
		start[1] = bias_store_done;
		for (int g = 0; g < 2; g++)
		begin
			rd_on[g] = (state[g] == conv_ctrl_pkg::ld_load) && (rd_cnt[g] != LOAD_LEN[g]);
		end
	end

	assign read_weight_addr   = rd_cnt[0];
	assign read_weight_signal = rd_on[0];
	assign read_bias_addr     = rd_cnt[1];
	assign read_bias_signal   = rd_on[1];

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int g = 0; g < 2; g++)
			begin
				state[g]  <= conv_ctrl_pkg::ld_idle;
				rd_cnt[g] <= '0;
				cap_en[g] <= 1'b0;
			end
		end
		else
		begin
			for (int g = 0; g < 2; g++)
			begin
				// memory answers one cycle after the read
				cap_en[g] <= rd_on[g];
				case (state[g])
					conv_ctrl_pkg::ld_idle:
					begin
						rd_cnt[g] <= '0;
						if (start[g])
							state[g] <= conv_ctrl_pkg::ld_load;
					end
					conv_ctrl_pkg::ld_load:
					begin
						// last word is captured on this edge
						if (rd_cnt[g] == LOAD_LEN[g])
							state[g] <= conv_ctrl_pkg::ld_idle;
						else
							rd_cnt[g] <= rd_cnt[g] + 1'b1;
					end
					default: state[g] <= conv_ctrl_pkg::ld_idle;
				endcase
			end
		end
	end

	// flat order tap*channels+channel, so address a ends at index a
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < N_W; i++)
				weights[i / `CONV_OUT_CH][i % `CONV_OUT_CH] <= '0;
			for (int c = 0; c < N_B; c++)
				biases[c] <= '0;
		end
		else
		begin
			if (cap_en[0])
			begin
				for (int i = 0; i < N_W - 1; i++)
					weights[i / `CONV_OUT_CH][i % `CONV_OUT_CH] <=
						weights[(i + 1) / `CONV_OUT_CH][(i + 1) % `CONV_OUT_CH];
				weights[`CONV_TAPS-1][`CONV_OUT_CH-1] <= weight_data;
			end
			if (cap_en[1])
			begin
				for (int c = 0; c < N_B - 1; c++)
					biases[c] <= biases[c + 1];
				biases[N_B-1] <= bias_data;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/conv_ctrl_pkg.sv */
`default_nettype none

`include "conv_macros.svh"

package conv_ctrl_pkg;

	typedef logic [`CONV_ADDR_W-1:0] addr_t;
	typedef logic [3:0] coord_t;

	typedef enum logic {ld_idle, ld_load} load_state_t;

	// fill issues the pixel reads, run drains the window pipeline
	typedef enum logic [1:0] {sc_idle, sc_fill, sc_run} scan_state_t;

endpackage

`default_nettype wire

/* verilog/conv_data_pkg.sv */
`default_nettype none

`include "conv_macros.svh"

package conv_data_pkg;

	typedef logic [`CONV_PIXEL_W-1:0] pixel_t;
	typedef logic signed [`CONV_WEIGHT_W-1:0] weight_t;
	typedef logic signed [`CONV_BIAS_W-1:0] bias_t;

	// nine products plus bias without saturation
	typedef logic signed [`CONV_ACC_W-1:0] acc_t;

	// channel 0 in the lowest bits
	typedef acc_t [`CONV_OUT_CH-1:0] result_t;

endpackage

`default_nettype wire

/* include/conv_macros.svh */
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// image and kernel geometry
`define CONV_IMG_WIDTH 8
`define CONV_KERNEL 3
`define CONV_TAPS 9
`define CONV_OUT_CH 4
`define CONV_OUT_SIDE (`CONV_IMG_WIDTH - `CONV_KERNEL + 1)

// datapath widths
`define CONV_PIXEL_W 8
`define CONV_WEIGHT_W 8
`define CONV_BIAS_W 16
`define CONV_ACC_W 20
`define CONV_ADDR_W 8

`endif
